//--- hw/ppu_pkg.sv
/* ppu output back end package
   shared widths, config word fields, resolution and video-mode codes */

package ppu_pkg;

  // ==================================================
  // widths
  // ==================================================

  // bits per colour channel, default for the top level
  localparam int COLOR_W = 8;

  // config word and status word
  localparam int CFG_W   = 20;
  localparam int STATE_W = 7;

  // ==================================================
  // config word field positions
  // ==================================================

  // 4-bit target resolution
  localparam int CFG_RES_LSB     = 0;

  localparam int CFG_FORCE60_BIT = 4;
  localparam int CFG_FORCE50_BIT = 5;
  // low latency mode blocks the 50/60 Hz override
  localparam int CFG_LLM_BIT     = 6;
  localparam int CFG_VGA480_BIT  = 7;
  localparam int CFG_LIMRGB_BIT  = 8;

  // 240p scanlines
  localparam int CFG_SL240_EN_BIT  = 9;
  localparam int CFG_SL240_STR_LSB = 10;

  // 480i scanlines, link bit reuses the 240p strength
  localparam int CFG_SL480_EN_BIT   = 14;
  localparam int CFG_SL480_LINK_BIT = 15;
  localparam int CFG_SL480_STR_LSB  = 16;

  // ==================================================
  // codes
  // ==================================================

  typedef enum logic [3:0] {
    RES_240P  = 4'd0,
    RES_288P  = 4'd1,
    RES_480P  = 4'd2,
    RES_576P  = 4'd3,
    RES_720P  = 4'd4,
    RES_960P  = 4'd5,
    RES_1080P = 4'd6,
    RES_1200P = 4'd7,
    RES_1440P = 4'd8
  } res_e;

  // 240p60 has to stay at zero, it is the reset mode
  typedef enum logic [4:0] {
    VM_240P60  = 5'd0,
    VM_480P60  = 5'd1,
    VM_VGAP60  = 5'd2,
    VM_720P60  = 5'd3,
    VM_960P60  = 5'd4,
    VM_1080P60 = 5'd5,
    VM_1200P60 = 5'd6,
    VM_1440P60 = 5'd7,
    VM_288P50  = 5'd8,
    VM_576P50  = 5'd9,
    VM_720P50  = 5'd10,
    VM_960P50  = 5'd11,
    VM_1080P50 = 5'd12,
    VM_1200P50 = 5'd13,
    VM_1440P50 = 5'd14
  } vmode_e;

  // ==================================================
  // post processing constants
  // ==================================================

  // scanline drawn from this relative row position on
  localparam logic [7:0] SL_POS_START = 8'hC0;

  // limited range, c*220/256 + 16
  localparam logic [7:0] LIM_COEFF  = 8'd220;
  localparam logic [7:0] LIM_OFFSET = 8'd16;

endpackage

//--- hw/ppu_cfg_decode.sv
/* configuration decode, resyncs config word and input flags to VCLK_Tx
   and resolves output video mode, scanline and limited range settings */

`timescale 1ns/1ps

module ppu_cfg_decode
  import ppu_pkg::*;
(
  input  logic               VCLK_Tx,
  input  logic               nVRST_Tx,
  input  logic [CFG_W-1:0]   config_i,
  input  logic               palmode_i,
  input  logic               n64_480i_i,
  output logic               sl_en_o,
  output logic [7:0]         sl_str_o,
  output logic               lim_en_o,
  output logic [STATE_W-1:0] ppu_state_o
);

  // ==================================================
  // two stage resync
  // ==================================================

  logic [CFG_W-1:0] cfg_s1, cfg_s2;
  logic             pal_s1, pal_s2;
  logic             i480_s1, i480_s2;

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      cfg_s1  <= '0;
      cfg_s2  <= '0;
      pal_s1  <= 1'b0;
      pal_s2  <= 1'b0;
      i480_s1 <= 1'b0;
      i480_s2 <= 1'b0;
    end else begin
      cfg_s1  <= config_i;
      cfg_s2  <= cfg_s1;
      pal_s1  <= palmode_i;
      pal_s2  <= pal_s1;
      i480_s1 <= n64_480i_i;
      i480_s2 <= i480_s1;
    end
  end

  // ==================================================
  // video mode tables
  // ==================================================

  res_e   res;
  logic   llm;
  logic   use_60, use_50;
  vmode_e vm_ntsc, vm_pal, vm_next;

  assign res = res_e'(cfg_s2[CFG_RES_LSB +: 4]);
  assign llm = cfg_s2[CFG_LLM_BIT];

  // override not allowed in llm or against the native line count
  assign use_60 = cfg_s2[CFG_FORCE60_BIT] && !llm && (res != RES_288P);
  assign use_50 = cfg_s2[CFG_FORCE50_BIT] && !llm && (res != RES_240P);

  always_comb begin
    case (res)
      RES_240P:  vm_ntsc = VM_240P60;
      RES_720P:  vm_ntsc = VM_720P60;
      RES_960P:  vm_ntsc = VM_960P60;
      RES_1080P: vm_ntsc = VM_1080P60;
      RES_1200P: vm_ntsc = VM_1200P60;
      RES_1440P: vm_ntsc = VM_1440P60;
      default:   vm_ntsc = cfg_s2[CFG_VGA480_BIT] ? VM_VGAP60 : VM_480P60;
    endcase
  end

  always_comb begin
    case (res)
      RES_576P:  vm_pal = VM_576P50;
      RES_720P:  vm_pal = VM_720P50;
      RES_960P:  vm_pal = VM_960P50;
      RES_1080P: vm_pal = VM_1080P50;
      RES_1200P: vm_pal = VM_1200P50;
      RES_1440P: vm_pal = VM_1440P50;
      default:   vm_pal = VM_288P50;
    endcase
  end

  always_comb begin
    if (use_60)
      vm_next = vm_ntsc;
    else if (use_50)
      vm_next = vm_pal;
    else
      vm_next = pal_s2 ? vm_pal : vm_ntsc;
  end

  // ==================================================
  // scanline selection
  // ==================================================

  logic       sl_en_next;
  logic [3:0] sl_str4;

  always_comb begin
    if (!i480_s2) begin
      sl_en_next = cfg_s2[CFG_SL240_EN_BIT];
      sl_str4    = cfg_s2[CFG_SL240_STR_LSB +: 4];
    end else begin
      sl_en_next = cfg_s2[CFG_SL480_EN_BIT];
      // linked 480i follows the 240p strength
      sl_str4    = cfg_s2[CFG_SL480_LINK_BIT] ? cfg_s2[CFG_SL240_STR_LSB +: 4]
                                              : cfg_s2[CFG_SL480_STR_LSB +: 4];
    end
  end

  // ==================================================
  // decode register
  // ==================================================

  vmode_e vmode_q;
  logic   pal_q, i480_q;

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      vmode_q  <= VM_240P60;
      pal_q    <= 1'b0;
      i480_q   <= 1'b0;
      sl_en_o  <= 1'b0;
      sl_str_o <= 8'd0;
      lim_en_o <= 1'b0;
    end else begin
      vmode_q  <= vm_next;
      pal_q    <= pal_s2;
      i480_q   <= i480_s2;
      sl_en_o  <= sl_en_next;
      // 16*(s+1)-1
      sl_str_o <= {sl_str4, 4'hF};
      lim_en_o <= cfg_s2[CFG_LIMRGB_BIT];
    end
  end

  assign ppu_state_o = {vmode_q, i480_q, pal_q};

endmodule

//--- hw/scanline_emu.sv
/* scanline emulation, darkens pixels on scanline rows by the strength
   two cycle pipeline for syncs and pixels */

`timescale 1ns/1ps

module scanline_emu
  import ppu_pkg::*;
#(
  parameter int COLOR_W = ppu_pkg::COLOR_W
) (
  input  logic                 VCLK_Tx,
  input  logic                 nVRST_Tx,
  input  logic                 hsync_i,
  input  logic                 vsync_i,
  input  logic                 de_i,
  input  logic [3*COLOR_W-1:0] vd_i,
  input  logic [7:0]           sl_rel_pos_i,
  input  logic                 sl_en_i,
  input  logic [7:0]           sl_str_i,
  output logic                 hsync_o,
  output logic                 vsync_o,
  output logic                 de_o,
  output logic [3*COLOR_W-1:0] vd_o
);

  logic [COLOR_W+7:0] prod_q [3];
  logic [COLOR_W-1:0] col_q  [3];
  logic               sl_draw_q;
  logic [1:0]         hs_q, vs_q, de_q;

  // ==================================================
  // stage 1, channel times strength
  // ==================================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      for (int ch = 0; ch < 3; ch++) begin
        prod_q[ch] <= '0;
        col_q[ch]  <= '0;
      end
      sl_draw_q <= 1'b0;
    end else begin
      for (int ch = 0; ch < 3; ch++) begin
        prod_q[ch] <= (COLOR_W+8)'(vd_i[ch*COLOR_W +: COLOR_W]) * (COLOR_W+8)'(sl_str_i);
        col_q[ch]  <= vd_i[ch*COLOR_W +: COLOR_W];
      end
      sl_draw_q <= sl_en_i && (sl_rel_pos_i >= SL_POS_START);
    end
  end

  // ==================================================
  // stage 2, subtract the scaled part on scanline rows
  // ==================================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      vd_o <= '0;
    end else begin
      for (int ch = 0; ch < 3; ch++) begin
        if (sl_draw_q)
          vd_o[ch*COLOR_W +: COLOR_W] <= col_q[ch] - prod_q[ch][COLOR_W+7:8];
        else
          vd_o[ch*COLOR_W +: COLOR_W] <= col_q[ch];
      end
    end
  end

  // syncs follow the pixel pipe
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      hs_q <= '0;
      vs_q <= '0;
      de_q <= '0;
    end else begin
      hs_q <= {hs_q[0], hsync_i};
      vs_q <= {vs_q[0], vsync_i};
      de_q <= {de_q[0], de_i};
    end
  end

  assign hsync_o = hs_q[1];
  assign vsync_o = vs_q[1];
  assign de_o    = de_q[1];

endmodule

//--- hw/rgb_limiter.sv
/* rgb output stage, optional full to limited range mapping (16..235)
   and the final sync, de and pixel registers */

`timescale 1ns/1ps

module rgb_limiter
  import ppu_pkg::*;
#(
  parameter int COLOR_W = ppu_pkg::COLOR_W
) (
  input  logic                 VCLK_Tx,
  input  logic                 nVRST_Tx,
  input  logic                 hsync_i,
  input  logic                 vsync_i,
  input  logic                 de_i,
  input  logic [3*COLOR_W-1:0] vd_i,
  input  logic                 lim_en_i,
  output logic                 hsync_o,
  output logic                 vsync_o,
  output logic                 de_o,
  output logic [3*COLOR_W-1:0] vd_o
);

  logic [COLOR_W+7:0]   lim_prod [3];
  logic [COLOR_W:0]     lim_q1   [3];
  logic [COLOR_W-1:0]   lim_q2   [3];
  logic [3*COLOR_W-1:0] full_q1, full_q2;
  logic [2:0]           hs_q, vs_q, de_q;

  // c * 220, one extra bit kept below the /256 point for rounding
  always_comb begin
    for (int ch = 0; ch < 3; ch++)
      lim_prod[ch] = (COLOR_W+8)'(vd_i[ch*COLOR_W +: COLOR_W]) * (COLOR_W+8)'(LIM_COEFF);
  end

  // ==================================================
  // stages 1 and 2, scale and round half up
  // ==================================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      for (int ch = 0; ch < 3; ch++) begin
        lim_q1[ch] <= '0;
        lim_q2[ch] <= '0;
      end
      full_q1 <= '0;
      full_q2 <= '0;
    end else begin
      for (int ch = 0; ch < 3; ch++) begin
        lim_q1[ch] <= lim_prod[ch][COLOR_W+7:7];
        lim_q2[ch] <= lim_q1[ch][COLOR_W:1] + COLOR_W'(lim_q1[ch][0]);
      end
      full_q1 <= vd_i;
      full_q2 <= full_q1;
    end
  end

  // ==================================================
  // stage 3, offset and output registers
  // ==================================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      vd_o <= '0;
    end else if (lim_en_i) begin
      for (int ch = 0; ch < 3; ch++)
        vd_o[ch*COLOR_W +: COLOR_W] <= lim_q2[ch] + COLOR_W'(LIM_OFFSET);
    end else begin
      vd_o <= full_q2;
    end
  end

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      hs_q <= '0;
      vs_q <= '0;
      de_q <= '0;
    end else begin
      hs_q <= {hs_q[1:0], hsync_i};
      vs_q <= {vs_q[1:0], vsync_i};
      de_q <= {de_q[1:0], de_i};
    end
  end

  assign hsync_o = hs_q[2];
  assign vsync_o = vs_q[2];
  assign de_o    = de_q[2];

endmodule

//--- hw/ppu_out_top.sv
/* transmit clock back end of the post processing unit
   config decode, scanline emulation and rgb output stage */

`timescale 1ns/1ps

module ppu_out_top
  import ppu_pkg::*;
#(
  parameter int COLOR_W = ppu_pkg::COLOR_W
) (
  input  logic                 VCLK_Tx,
  input  logic                 nVRST_Tx,
  // async levels
  input  logic [CFG_W-1:0]     config_i,
  input  logic                 palmode_i,
  input  logic                 n64_480i_i,
  // scaled video, one pixel per cycle
  input  logic                 hsync_i,
  input  logic                 vsync_i,
  input  logic                 de_i,
  input  logic [3*COLOR_W-1:0] vd_i,
  input  logic [7:0]           sl_rel_pos_i,
  output logic [STATE_W-1:0]   ppu_state_o,
  output logic                 hsync_o,
  output logic                 vsync_o,
  output logic                 de_o,
  output logic [3*COLOR_W-1:0] vd_o
);

  logic                 sl_en;
  logic [7:0]           sl_str;
  logic                 lim_en;
  logic                 sl_hsync, sl_vsync, sl_de;
  logic [3*COLOR_W-1:0] sl_vd;

  // ==================================================
  // settings
  // ==================================================

  ppu_cfg_decode ppu_cfg_decode_i (
    .VCLK_Tx     (VCLK_Tx),
    .nVRST_Tx    (nVRST_Tx),
    .config_i    (config_i),
    .palmode_i   (palmode_i),
    .n64_480i_i  (n64_480i_i),
    .sl_en_o     (sl_en),
    .sl_str_o    (sl_str),
    .lim_en_o    (lim_en),
    .ppu_state_o (ppu_state_o)
  );

  // ==================================================
  // video path
  // ==================================================

  scanline_emu #(
    .COLOR_W (COLOR_W)
  ) scanline_emu_i (
    .VCLK_Tx      (VCLK_Tx),
    .nVRST_Tx     (nVRST_Tx),
    .hsync_i      (hsync_i),
    .vsync_i      (vsync_i),
    .de_i         (de_i),
    .vd_i         (vd_i),
    .sl_rel_pos_i (sl_rel_pos_i),
    .sl_en_i      (sl_en),
    .sl_str_i     (sl_str),
    .hsync_o      (sl_hsync),
    .vsync_o      (sl_vsync),
    .de_o         (sl_de),
    .vd_o         (sl_vd)
  );

  rgb_limiter #(
    .COLOR_W (COLOR_W)
  ) rgb_limiter_i (
    .VCLK_Tx  (VCLK_Tx),
    .nVRST_Tx (nVRST_Tx),
    .hsync_i  (sl_hsync),
    .vsync_i  (sl_vsync),
    .de_i     (sl_de),
    .vd_i     (sl_vd),
    .lim_en_i (lim_en),
    .hsync_o  (hsync_o),
    .vsync_o  (vsync_o),
    .de_o     (de_o),
    .vd_o     (vd_o)
  );

endmodule

//--- sim/ppu_out_asserts.sv
/* output assertions for the ppu back end, bound into the top level */

`timescale 1ns/1ps

module ppu_out_asserts
  import ppu_pkg::*;
#(
  parameter int COLOR_W = ppu_pkg::COLOR_W
) (
  input logic                 VCLK_Tx,
  input logic                 nVRST_Tx,
  input logic                 hsync_i,
  input logic                 vsync_i,
  input logic                 de_i,
  input logic [3*COLOR_W-1:0] vd_i,
  input logic [STATE_W-1:0]   state_i,
  input logic                 lim_en_i
);

  function automatic logic in_limited(input logic [3*COLOR_W-1:0] vd);
    logic ok;
    ok = 1'b1;
    for (int ch = 0; ch < 3; ch++) begin
      if (vd[ch*COLOR_W +: COLOR_W] < COLOR_W'(LIM_OFFSET) ||
          vd[ch*COLOR_W +: COLOR_W] > COLOR_W'(235))
        ok = 1'b0;
    end
    return ok;
  endfunction

  no_x_out: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    !$isunknown({state_i, hsync_i, vsync_i, de_i, vd_i}))
    else $error("unknown value on outputs");

  // every stage filled while limited range was on
  lim_range: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    (lim_en_i && $past(lim_en_i) && $past(lim_en_i, 2) && $past(lim_en_i, 3))
    |-> in_limited(vd_i))
    else $error("pixel outside 16..235 in limited range");

  reset_zero: assert property (@(posedge VCLK_Tx)
    !nVRST_Tx |-> ({state_i, hsync_i, vsync_i, de_i, vd_i} == '0))
    else $error("outputs not cleared in reset");

endmodule

bind ppu_out_top ppu_out_asserts #(
  .COLOR_W (COLOR_W)
) ppu_out_asserts_i (
  .VCLK_Tx  (VCLK_Tx),
  .nVRST_Tx (nVRST_Tx),
  .hsync_i  (hsync_o),
  .vsync_i  (vsync_o),
  .de_i     (de_o),
  .vd_i     (vd_o),
  .state_i  (ppu_state_o),
  .lim_en_i (lim_en)
);

//--- sim/tb_ppu_out.sv
/* directed testbench for the ppu output back end
   reset, pass-through, limited range, scanlines and video mode decode */

`timescale 1ns/1ps

module tb_ppu_out
  import ppu_pkg::*;
;

  localparam int CLK_PERIOD = 4;
  localparam int RST_CYCLES = 5;
  localparam int SETTLE     = 8;
  localparam int PIPE_LAT   = 5;
  localparam int N_PIX      = 64;
  // six video setups, 28 video mode cases
  localparam int N_VID_CFG  = 6;
  localparam int N_MODE_CFG = 28;
  localparam int VEC_CYCLES = RST_CYCLES + 1 + N_VID_CFG * (N_PIX + 2 + PIPE_LAT);
  localparam int SET_CYCLES = (N_VID_CFG + N_MODE_CFG) * (SETTLE + 2);
  localparam int WD_NS      = 2 * (VEC_CYCLES + SET_CYCLES) * CLK_PERIOD;

  // 50 and 60 Hz tables indexed by res_e
  localparam vmode_e NTSC_TBL [9] = '{VM_240P60, VM_480P60, VM_480P60, VM_480P60,
    VM_720P60, VM_960P60, VM_1080P60, VM_1200P60, VM_1440P60};
  localparam vmode_e PAL_TBL [9] = '{VM_288P50, VM_288P50, VM_288P50, VM_576P50,
    VM_720P50, VM_960P50, VM_1080P50, VM_1200P50, VM_1440P50};

  logic                 VCLK_Tx;
  logic                 nVRST_Tx;
  logic [CFG_W-1:0]     config_i;
  logic                 palmode_i;
  logic                 n64_480i_i;
  logic                 hsync_i;
  logic                 vsync_i;
  logic                 de_i;
  logic [3*COLOR_W-1:0] vd_i;
  logic [7:0]           sl_rel_pos_i;
  logic [STATE_W-1:0]   ppu_state_o;
  logic                 hsync_o;
  logic                 vsync_o;
  logic                 de_o;
  logic [3*COLOR_W-1:0] vd_o;

  // expected post processing settings
  logic exp_lim;
  logic exp_sl_en;
  int   exp_sl_str;

  // {hsync, vsync, de, pixel} expected on the outputs
  logic [3*COLOR_W+2:0] exp_q [$];

  ppu_out_top #(
    .COLOR_W (COLOR_W)
  ) ppu_out_top_i (
    .VCLK_Tx      (VCLK_Tx),
    .nVRST_Tx     (nVRST_Tx),
    .config_i     (config_i),
    .palmode_i    (palmode_i),
    .n64_480i_i   (n64_480i_i),
    .hsync_i      (hsync_i),
    .vsync_i      (vsync_i),
    .de_i         (de_i),
    .vd_i         (vd_i),
    .sl_rel_pos_i (sl_rel_pos_i),
    .ppu_state_o  (ppu_state_o),
    .hsync_o      (hsync_o),
    .vsync_o      (vsync_o),
    .de_o         (de_o),
    .vd_o         (vd_o)
  );

  always #(CLK_PERIOD / 2) VCLK_Tx = ~VCLK_Tx;

  // ==================================================
  // helpers
  // ==================================================

  task automatic check_eq(input logic [63:0] act, input logic [63:0] exp, input string msg);
    if (act !== exp) begin
      $display("ERROR at %0t: %s got %h expected %h", $time, msg, act, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "output value mismatch");
    end
  endtask

  function automatic logic [CFG_W-1:0] cfg_bit(input int pos);
    return CFG_W'(1) << pos;
  endfunction

  function automatic logic [CFG_W-1:0] sl_cfg(input logic en240, input logic [3:0] s240,
                                              input logic en480, input logic link,
                                              input logic [3:0] s480);
    logic [CFG_W-1:0] cfg;
    cfg = '0;
    cfg[CFG_SL240_EN_BIT]          = en240;
    cfg[CFG_SL240_STR_LSB +: 4]    = s240;
    cfg[CFG_SL480_EN_BIT]          = en480;
    cfg[CFG_SL480_LINK_BIT]        = link;
    cfg[CFG_SL480_STR_LSB +: 4]    = s480;
    return cfg;
  endfunction

  // reference pixel, scanline first and then range mapping
  function automatic logic [3*COLOR_W-1:0] expect_vd(input logic [3*COLOR_W-1:0] vd,
                                                     input logic [7:0] pos);
    logic [3*COLOR_W-1:0] out;
    int                   c;
    for (int ch = 0; ch < 3; ch++) begin
      c = int'(vd[ch*COLOR_W +: COLOR_W]);
      if (exp_sl_en && pos >= SL_POS_START)
        c = c - (c * exp_sl_str) / 256;
      // round half up
      if (exp_lim)
        c = (c * int'(LIM_COEFF) + 128) / 256 + int'(LIM_OFFSET);
      out[ch*COLOR_W +: COLOR_W] = COLOR_W'(c);
    end
    return out;
  endfunction

  // checks the pixel driven PIPE_LAT calls ago, then drives a new one
  task automatic drive_pixel(input logic hs, input logic vs, input logic de,
                             input logic [3*COLOR_W-1:0] vd, input logic [7:0] pos);
    logic [3*COLOR_W+2:0] exp;
    @(posedge VCLK_Tx);
    #0.5;
    if (exp_q.size() == PIPE_LAT) begin
      exp = exp_q.pop_front();
      check_eq(64'({hsync_o, vsync_o, de_o, vd_o}), 64'(exp), "video out");
    end
    hsync_i      = hs;
    vsync_i      = vs;
    de_i         = de;
    vd_i         = vd;
    sl_rel_pos_i = pos;
    exp_q.push_back({hs, vs, de, expect_vd(vd, pos)});
  endtask

  task automatic drive_random(input int n);
    repeat (n)
      drive_pixel(1'($urandom), 1'($urandom), 1'($urandom), (3*COLOR_W)'($urandom),
                  8'($urandom));
  endtask

  task automatic flush_pipe();
    repeat (PIPE_LAT) drive_pixel(1'b0, 1'b0, 1'b0, '0, 8'h00);
    exp_q.delete();
  endtask

  task automatic apply_config(input logic [CFG_W-1:0] cfg, input logic i480,
                              input logic sl_on, input int s);
    @(posedge VCLK_Tx);
    #0.5;
    config_i   = cfg;
    palmode_i  = 1'b0;
    n64_480i_i = i480;
    exp_lim    = cfg[CFG_LIMRGB_BIT];
    exp_sl_en  = sl_on;
    exp_sl_str = 16 * (s + 1) - 1;
    repeat (SETTLE) @(posedge VCLK_Tx);
  endtask

  task automatic mode_case(input logic [CFG_W-1:0] cfg, input logic pal, input logic i480,
                           input vmode_e vm);
    @(posedge VCLK_Tx);
    #0.5;
    config_i   = cfg;
    palmode_i  = pal;
    n64_480i_i = i480;
    repeat (SETTLE) @(posedge VCLK_Tx);
    #0.5;
    check_eq(64'(ppu_state_o), 64'({vm, i480, pal}), "ppu_state");
  endtask

  // ==================================================
  // tests
  // ==================================================

  task automatic reset_values();
    repeat (RST_CYCLES) begin
      @(posedge VCLK_Tx);
      #0.5;
      check_eq(64'({ppu_state_o, hsync_o, vsync_o, de_o, vd_o}), 64'(0), "in reset");
    end
    nVRST_Tx = 1'b1;
    @(posedge VCLK_Tx);
    #0.5;
    check_eq(64'({ppu_state_o, hsync_o, vsync_o, de_o, vd_o}), 64'(0), "after reset");
  endtask

  task automatic passthrough_video();
    apply_config('0, 1'b0, 1'b0, 0);
    drive_random(N_PIX);
    flush_pipe();
  endtask

  task automatic limited_range();
    apply_config(cfg_bit(CFG_LIMRGB_BIT), 1'b0, 1'b0, 0);
    drive_pixel(1'b0, 1'b0, 1'b1, '0, 8'h00);
    drive_pixel(1'b1, 1'b1, 1'b1, '1, 8'hFF);
    drive_random(N_PIX);
    flush_pipe();
  endtask

  task automatic scanlines_240p();
    apply_config(sl_cfg(1'b1, 4'd9, 1'b0, 1'b0, 4'd0), 1'b0, 1'b1, 9);
    // both sides of the scanline start row
    drive_pixel(1'b0, 1'b0, 1'b1, '1, SL_POS_START - 8'd1);
    drive_pixel(1'b0, 1'b0, 1'b1, '1, SL_POS_START);
    drive_random(N_PIX);
    flush_pipe();
  endtask

  task automatic scanlines_480i();
    // 480i enable off, 240p enable ignored
    apply_config(sl_cfg(1'b1, 4'd5, 1'b0, 1'b0, 4'd12), 1'b1, 1'b0, 0);
    drive_random(N_PIX);
    flush_pipe();
    // linked to the 240p strength
    apply_config(sl_cfg(1'b0, 4'd5, 1'b1, 1'b1, 4'd12), 1'b1, 1'b1, 5);
    drive_random(N_PIX);
    flush_pipe();
    apply_config(sl_cfg(1'b0, 4'd5, 1'b1, 1'b0, 4'd12), 1'b1, 1'b1, 12);
    drive_random(N_PIX);
    flush_pipe();
  endtask

  task automatic video_mode_table();
    for (int r = 0; r < 9; r++) begin
      mode_case(CFG_W'(r), 1'b0, 1'b0, NTSC_TBL[r]);
      mode_case(CFG_W'(r), 1'b1, 1'b0, PAL_TBL[r]);
    end
    mode_case(CFG_W'(RES_480P) | cfg_bit(CFG_VGA480_BIT), 1'b0, 1'b0, VM_VGAP60);
    mode_case(CFG_W'(RES_576P) | cfg_bit(CFG_VGA480_BIT), 1'b0, 1'b0, VM_VGAP60);
    mode_case(CFG_W'(RES_480P) | cfg_bit(CFG_VGA480_BIT), 1'b1, 1'b0, VM_288P50);
    // force 60 on a PAL source
    mode_case(CFG_W'(RES_720P) | cfg_bit(CFG_FORCE60_BIT), 1'b1, 1'b0, VM_720P60);
    mode_case(CFG_W'(RES_720P) | cfg_bit(CFG_FORCE60_BIT) | cfg_bit(CFG_LLM_BIT), 1'b1,
              1'b0, VM_720P50);
    mode_case(CFG_W'(RES_288P) | cfg_bit(CFG_FORCE60_BIT), 1'b1, 1'b0, VM_288P50);
    // force 50 on an NTSC source
    mode_case(CFG_W'(RES_1080P) | cfg_bit(CFG_FORCE50_BIT), 1'b0, 1'b0, VM_1080P50);
    mode_case(CFG_W'(RES_1080P) | cfg_bit(CFG_FORCE50_BIT) | cfg_bit(CFG_LLM_BIT), 1'b0,
              1'b0, VM_1080P60);
    mode_case(CFG_W'(RES_240P) | cfg_bit(CFG_FORCE50_BIT), 1'b0, 1'b0, VM_240P60);
    mode_case(CFG_W'(RES_960P), 1'b1, 1'b1, VM_960P50);
  endtask

  // ==================================================
  // main sequence and watchdog
  // ==================================================

  initial begin
    VCLK_Tx      = 1'b0;
    nVRST_Tx     = 1'b0;
    config_i     = '0;
    palmode_i    = 1'b0;
    n64_480i_i   = 1'b0;
    hsync_i      = 1'b0;
    vsync_i      = 1'b0;
    de_i         = 1'b0;
    vd_i         = '0;
    sl_rel_pos_i = 8'h00;
    exp_lim      = 1'b0;
    exp_sl_en    = 1'b0;
    exp_sl_str   = 0;
    void'($urandom(32'h121c));
    reset_values();
    passthrough_video();
    limited_range();
    scanlines_240p();
    scanlines_480i();
    video_mode_table();
    $display("Simulation finished: PASS");
    $finish;
  end

  initial begin
    #(WD_NS);
    $display("watchdog expired before the tests completed");
    $display("Simulation finished: FAIL");
    $fatal(1, "timeout");
  end

endmodule

//--- all.f
hw/ppu_pkg.sv
hw/ppu_cfg_decode.sv
hw/scanline_emu.sv
hw/rgb_limiter.sv
hw/ppu_out_top.sv
sim/ppu_out_asserts.sv
sim/tb_ppu_out.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the ppu output testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_ppu_out -f all.f -o tb_ppu_out &&
./obj_dir/tb_ppu_out ||
{ echo "simulation failed"; exit 1; }
